// File: verilog.f
hw/pkt_buf_pkg.sv
hw/dp_sram.sv
hw/pkt_space_ctrl.sv
hw/pkt_writer.sv
hw/pkt_reader.sv
hw/pkt_buffer.sv
sim/pkt_buffer_props.sv
sim/tb_pkt_buffer.sv

// File: Bender.yml
package:
  name: pkt_buffer

sources:
  - hw/pkt_buf_pkg.sv
  - hw/dp_sram.sv
  - hw/pkt_space_ctrl.sv
  - hw/pkt_writer.sv
  - hw/pkt_reader.sv
  - hw/pkt_buffer.sv
  - target: simulation
    files:
      - sim/pkt_buffer_props.sv
      - sim/tb_pkt_buffer.sv

// File: sim/tb_pkt_buffer.sv
// ----------------------------------------------------------------------
// testbench for pkt_buffer
// table of packets written, dropped and drained against a space model
// ----------------------------------------------------------------------

module tb_pkt_buffer;
	timeunit 1ns;
	timeprecision 1ps;

	logic               clk_a;
	logic               reset;
	logic               in_en;
	pkt_buf_pkg::word_t in_data;
	logic               in_last;
	logic               drop;
	logic               out_start;
	logic               pkt_avail;
	logic               out_valid;
	pkt_buf_pkg::word_t out_data;
	logic               out_last;
	logic               busy;

	// one packet per row, drain reads back everything stored so far
	typedef struct packed {
		logic [7:0] len;
		logic       drain;
		logic       drop;		// expected drop at in_last
	} row_t;

	localparam int N_ROWS = 26;
	row_t rows [N_ROWS] = '{
		'{5, 1, 0},									// single short packet
		'{1, 0, 0}, '{64, 1, 0},					// shortest and longest back to back
		'{64, 0, 0}, '{64, 0, 0}, '{64, 0, 0},		// fill the data ram
		'{64, 0, 0}, '{64, 1, 1},					// no room left for the fifth
		'{40, 1, 0},								// space back after the wrap
		'{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0},
		'{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0}, '{1, 0, 0},
		'{1, 0, 0}, '{1, 0, 0}, '{1, 1, 1}			// ring full on the seventeenth
	};

	integer             seed = 65;
	pkt_buf_pkg::word_t exp_words [$];	// words of admitted packets, write order
	int                 exp_lens [$];
	int                 used_m = 0;		// model used words
	int                 desc_m = 0;		// model stored descriptors
	int                 n_checks = 0;
	int                 word_errs = 0;
	int                 bit_errs = 0;
	int                 len_errs = 0;
	int                 other_errs = 0;

	pkt_buffer i_dut (.*);

	initial begin
		clk_a = 1'b0;
		forever #5 clk_a = ~clk_a;
	end

	function automatic int error_total();
		return word_errs + bit_errs + len_errs + other_errs + i_dut.i_props.fail_count;
	endfunction

	// two cycles per word plus a fixed allowance for each row and for reset
	function automatic int timeout_limit();
		int t;
		t = 20;
		foreach (rows[i])
			t += 2 * rows[i].len + 20;
		return t;
	endfunction

	task automatic check_word(input string name, input pkt_buf_pkg::word_t got,
			input pkt_buf_pkg::word_t exp);
		n_checks++;
		if (got !== exp) begin
			word_errs++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			bit_errs++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_len(input string name, input logic [pkt_buf_pkg::LEN_W-1:0] got,
			input logic [pkt_buf_pkg::LEN_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			len_errs++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	// one word per cycle, drop sampled mid-cycle
	task automatic send_packet(input int len, input logic keep, output logic saw_drop);
		pkt_buf_pkg::word_t w;
		saw_drop = 1'b0;
		for (int i = 0; i < len; i++) begin
			w = $random(seed);
			@(posedge clk_a);
			in_en   <= 1'b1;
			in_data <= w;
			in_last <= (i == len - 1);
			if (keep)
				exp_words.push_back(w);
			@(negedge clk_a);
			if (drop)
				saw_drop = 1'b1;
		end
		@(posedge clk_a);
		in_en   <= 1'b0;
		in_last <= 1'b0;
	endtask

	// request the oldest packet and compare it word by word
	task automatic read_packet();
		int len;
		int n;
		logic done;
		len  = exp_lens.pop_front();
		n    = 0;
		done = 1'b0;
		while (!pkt_avail)
			@(negedge clk_a);
		@(posedge clk_a);
		out_start <= 1'b1;
		@(posedge clk_a);
		out_start <= 1'b0;
		while (!done) begin
			@(negedge clk_a);
			if (out_valid) begin
				check_bit("busy", busy, 1'b1);
				if (n < len) begin
					check_word("out_data", out_data, exp_words.pop_front());
					check_bit("out_last", out_last, n == len - 1);
				end else begin
					other_errs++;
					$display("packet delivered more words than the %0d it holds", len);
				end
				n++;
				done = out_last;
			end
		end
		check_len("packet length", n, len);
		for (int i = n; i < len; i++)
			void'(exp_words.pop_front());	// keep later packets aligned
		@(negedge clk_a);
		check_bit("busy", busy, 1'b0);		// reader idle one cycle after out_last
		used_m -= len;
		desc_m--;
	endtask

	task automatic run_row(input int r);
		logic keep;
		logic saw_drop;
		// space measured before the first word
		keep = (used_m + pkt_buf_pkg::MAX_PKT_WORDS <= pkt_buf_pkg::DATA_DEPTH) &&
			(desc_m < pkt_buf_pkg::DESC_DEPTH);
		if (keep == rows[r].drop) begin
			other_errs++;
			$display("row %0d expects drop %0b but the space model says %0b", r,
				rows[r].drop, !keep);
		end
		send_packet(rows[r].len, keep, saw_drop);
		check_bit("drop", saw_drop, !keep);
		if (keep) begin
			used_m += rows[r].len;
			desc_m++;
			exp_lens.push_back(rows[r].len);
		end
		repeat (2) @(negedge clk_a);	// descriptor visible 2 cycles after in_last
		check_bit("pkt_avail", pkt_avail, desc_m != 0);
		if (rows[r].drain) begin
			while (exp_lens.size() != 0)
				read_packet();
			@(negedge clk_a);
			check_bit("pkt_avail", pkt_avail, 1'b0);
		end
		$display("row %0d: %0d words %s, %0d errors so far", r, rows[r].len,
			keep ? "kept" : "dropped", error_total());
	endtask

	initial begin : main
		reset     <= 1'b1;
		in_en     <= 1'b0;
		in_data   <= '0;
		in_last   <= 1'b0;
		out_start <= 1'b0;
		repeat (5) @(posedge clk_a);
		reset <= 1'b0;
		@(negedge clk_a);
		check_bit("drop", drop, 1'b0);		// all outputs idle out of reset
		check_bit("pkt_avail", pkt_avail, 1'b0);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("out_last", out_last, 1'b0);
		check_bit("busy", busy, 1'b0);
		$display("reset: %0d errors so far", error_total());
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		$display("%0d checks, word errors %0d, bit errors %0d, length errors %0d, %s %0d, %s %0d",
			n_checks, word_errs, bit_errs, len_errs, "other errors", other_errs,
			"assertion failures", i_dut.i_props.fail_count);
		if (error_total() == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin : watchdog
		int limit;
		int cycles;
		limit  = timeout_limit();
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk_a);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: sim/pkt_buffer_props.sv
// ----------------------------------------------------------------------
// pkt_buffer_props
// interface rules of the packet buffer, bound into every pkt_buffer
// ----------------------------------------------------------------------

module pkt_buffer_props (
	input logic clk_a,
	input logic reset,
	input logic in_en,
	input logic in_last,
	input logic drop,
	input logic pkt_avail,
	input logic out_valid,
	input logic out_last,
	input logic busy
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;		// read by the testbench at the end

	a_last_valid: assert property (@(posedge clk_a) disable iff (reset)
		out_last |-> out_valid)
		else begin
			fail_count++;
			$error("out_last without out_valid");
		end

	a_drop_last: assert property (@(posedge clk_a) disable iff (reset)
		drop |-> (in_en && in_last))		// whole packet decided at its end
		else begin
			fail_count++;
			$error("drop outside the in_last cycle");
		end

	a_valid_busy: assert property (@(posedge clk_a) disable iff (reset)
		!busy |-> !out_valid)
		else begin
			fail_count++;
			$error("out_valid while the reader is idle");
		end

	// outputs are cleared by the reset edge itself
	a_reset_idle: assert property (@(posedge clk_a)
		reset |=> (!drop && !pkt_avail && !out_valid && !out_last && !busy))
		else begin
			fail_count++;
			$error("outputs not idle after reset");
		end

endmodule

bind pkt_buffer pkt_buffer_props i_props (.*);

// File: hw/pkt_buffer.sv
// ---------------------------------------------------------------------
// pkt_buffer
// packet buffer top, data ram and descriptor ring with the writer,
// reader and space controller around them
// ---------------------------------------------------------------------

module pkt_buffer (
	input  logic               clk_a,
	input  logic               reset,
	// producer side
	input  logic               in_en,
	input  pkt_buf_pkg::word_t in_data,
	input  logic               in_last,
	output logic               drop,
	// consumer side
	input  logic               out_start,
	output logic               pkt_avail,
	output logic               out_valid,
	output pkt_buf_pkg::word_t out_data,
	output logic               out_last,
	output logic               busy
);

	logic                            wr_en;
	logic [pkt_buf_pkg::DATA_AW-1:0] wr_addr;
	pkt_buf_pkg::word_t              wr_data;
	logic                            rd_en;
	logic [pkt_buf_pkg::DATA_AW-1:0] rd_addr;
	pkt_buf_pkg::word_t              rd_data;

	logic                            desc_wr_en;
	logic [pkt_buf_pkg::DESC_AW-1:0] desc_wr_addr;
	pkt_buf_pkg::pkt_desc_t          desc_wr_data;
	logic                            desc_rd_en;
	logic [pkt_buf_pkg::DESC_AW-1:0] desc_rd_addr;
	pkt_buf_pkg::pkt_desc_t          desc_rd_data;

	logic                            admit;
	logic                            commit;
	logic [pkt_buf_pkg::LEN_W-1:0]   commit_len;
	logic                            release_pkt;
	logic [pkt_buf_pkg::LEN_W-1:0]   release_len;

	// packet words
	dp_sram #(.payload_t(pkt_buf_pkg::word_t), .ADDR_W(pkt_buf_pkg::DATA_AW)) i_data_ram (
		.clk_a, .reset, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
	);

	// descriptor ring
	dp_sram #(.payload_t(pkt_buf_pkg::pkt_desc_t), .ADDR_W(pkt_buf_pkg::DESC_AW)) i_desc_ram (
		.clk_a, .reset,
		.wr_en(desc_wr_en), .wr_addr(desc_wr_addr), .wr_data(desc_wr_data),
		.rd_en(desc_rd_en), .rd_addr(desc_rd_addr), .rd_data(desc_rd_data)
	);

	pkt_writer i_pkt_writer (
		.clk_a, .reset, .in_en, .in_data, .in_last, .admit, .drop,
		.wr_en, .wr_addr, .wr_data, .desc_wr_en, .desc_wr_addr, .desc_wr_data,
		.commit, .commit_len
	);

	pkt_reader i_pkt_reader (
		.clk_a, .reset, .out_start, .pkt_avail,
		.desc_rd_en, .desc_rd_addr, .desc_rd_data, .rd_en, .rd_addr, .rd_data,
		.out_valid, .out_data, .out_last, .busy, .release_pkt, .release_len
	);

	pkt_space_ctrl i_pkt_space_ctrl (
		.clk_a, .reset, .commit, .commit_len, .release_pkt, .release_len,
		.admit, .pkt_avail
	);

endmodule

// File: hw/pkt_reader.sv
// ---------------------------------------------------------------------
// pkt_reader
// on a start request fetches the oldest descriptor, then reads its
// words back to back and frees the packet with its last word
// ---------------------------------------------------------------------

module pkt_reader (
	input  logic                            clk_a,
	input  logic                            reset,
	input  logic                            out_start,
	input  logic                            pkt_avail,
	output logic                            desc_rd_en,	// descriptor ring read port
	output logic [pkt_buf_pkg::DESC_AW-1:0] desc_rd_addr,
	input  pkt_buf_pkg::pkt_desc_t          desc_rd_data,
	output logic                            rd_en,		// data ram read port
	output logic [pkt_buf_pkg::DATA_AW-1:0] rd_addr,
	input  pkt_buf_pkg::word_t              rd_data,
	output logic                            out_valid,
	output pkt_buf_pkg::word_t              out_data,
	output logic                            out_last,
	output logic                            busy,
	output logic                            release_pkt,
	output logic [pkt_buf_pkg::LEN_W-1:0]   release_len
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,		// waiting on the descriptor read
		S_STREAM		// word reads in flight
	} state_t;

	state_t                          state;
	logic                            fetch_wait;	// first fetch cycle
	logic [pkt_buf_pkg::DESC_AW-1:0] desc_ptr;		// oldest stored descriptor
	logic [pkt_buf_pkg::DATA_AW-1:0] rd_ptr;
	logic [pkt_buf_pkg::LEN_W-1:0]   remain;		// word reads still to issue
	logic [1:0]                      valid_sr;		// matches ram latency
	logic [1:0]                      last_sr;
	logic                            accept;
	logic                            first_issue;	// descriptor data present
	logic                            issue_last;

	assign accept      = (state == S_IDLE) && out_start && pkt_avail;
	assign first_issue = (state == S_FETCH) && !fetch_wait;

	assign desc_rd_en   = accept;
	assign desc_rd_addr = desc_ptr;

	always_comb begin
		rd_en   = first_issue || ((state == S_STREAM) && (remain != '0));
		rd_addr = first_issue ? desc_rd_data.start : rd_ptr;
		issue_last = first_issue ? (desc_rd_data.len == pkt_buf_pkg::LEN_W'(1)) :
			(remain == pkt_buf_pkg::LEN_W'(1));
	end

	always_ff @(posedge clk_a) begin
		if (reset) begin
			state      <= S_IDLE;
			fetch_wait <= 1'b0;
			desc_ptr   <= '0;
			remain     <= '0;
			valid_sr   <= '0;
			last_sr    <= '0;
		end else begin
			valid_sr <= {valid_sr[0], rd_en};
			last_sr  <= {last_sr[0], rd_en && issue_last};
			case (state)
				S_IDLE: if (accept) begin
					state      <= S_FETCH;
					fetch_wait <= 1'b1;
					desc_ptr   <= desc_ptr + 1'b1;
				end
				S_FETCH: begin
					if (fetch_wait)
						fetch_wait <= 1'b0;
					else begin
						state  <= S_STREAM;
						remain <= desc_rd_data.len - 1'b1;	// word 0 goes out now
					end
				end
				S_STREAM: begin
					if (rd_en)
						remain <= remain - 1'b1;
					if (out_last)
						state <= S_IDLE;	// busy drops next cycle
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_a) begin
		if (rd_en)
			rd_ptr <= rd_addr + 1'b1;
		if (first_issue)
			release_len <= desc_rd_data.len;
	end

	assign out_valid   = valid_sr[1];
	assign out_last    = last_sr[1];
	assign out_data    = rd_data;
	assign busy        = (state != S_IDLE);
	assign release_pkt = out_last;	// space freed behind the last read

endmodule

// File: hw/pkt_writer.sv
// ---------------------------------------------------------------------
// pkt_writer
// places incoming words at a wrapping write pointer, decides at the
// first word whether the whole packet is kept, and at the last word
// writes its descriptor or signals the drop
// ---------------------------------------------------------------------

module pkt_writer (
	input  logic                            clk_a,
	input  logic                            reset,
	input  logic                            in_en,
	input  pkt_buf_pkg::word_t              in_data,
	input  logic                            in_last,
	input  logic                            admit,		// sampled at first word only
	output logic                            drop,
	output logic                            wr_en,		// data ram write port
	output logic [pkt_buf_pkg::DATA_AW-1:0] wr_addr,
	output pkt_buf_pkg::word_t              wr_data,
	output logic                            desc_wr_en,	// descriptor ring write port
	output logic [pkt_buf_pkg::DESC_AW-1:0] desc_wr_addr,
	output pkt_buf_pkg::pkt_desc_t          desc_wr_data,
	output logic                            commit,
	output logic [pkt_buf_pkg::LEN_W-1:0]   commit_len
);

	logic                            first_q;		// next word opens a packet
	logic                            take_q;		// admit latched at first word
	logic                            take;			// current packet is kept
	logic [pkt_buf_pkg::DATA_AW-1:0] wr_ptr;
	logic [pkt_buf_pkg::DATA_AW-1:0] pkt_start_q;
	logic [pkt_buf_pkg::LEN_W-1:0]   len_q;			// words seen before this one
	logic [pkt_buf_pkg::LEN_W-1:0]   pkt_len;
	logic [pkt_buf_pkg::DESC_AW-1:0] desc_ptr;

	assign take    = first_q ? admit : take_q;
	assign pkt_len = len_q + 1'b1;

	// data ram write, only for admitted packets
	assign wr_en   = in_en && take;
	assign wr_addr = wr_ptr;
	assign wr_data = in_data;

	// descriptor goes out in the in_last cycle
	assign desc_wr_en   = in_en && in_last && take;
	assign desc_wr_addr = desc_ptr;
	always_comb begin
		desc_wr_data.start = first_q ? wr_ptr : pkt_start_q;	// 1-word packet
		desc_wr_data.len   = pkt_len;
	end

	assign drop = in_en && in_last && !take;

	always_ff @(posedge clk_a) begin
		if (reset) begin
			first_q  <= 1'b1;
			take_q   <= 1'b0;
			wr_ptr   <= '0;
			len_q    <= '0;
			desc_ptr <= '0;
			commit   <= 1'b0;
		end else begin
			commit <= desc_wr_en;			// one cycle after in_last
			if (in_en) begin
				first_q <= in_last;
				if (first_q)
					take_q <= admit;
				if (take)
					wr_ptr <= wr_ptr + 1'b1;	// wraps at 256
				// a dropped packet never moves wr_ptr, so the next one
				// starts where this one would have
				len_q <= in_last ? '0 : pkt_len;
			end
			if (desc_wr_en)
				desc_ptr <= desc_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_a) begin
		if (in_en && first_q)
			pkt_start_q <= wr_ptr;
		if (desc_wr_en)
			commit_len <= pkt_len;
	end

endmodule

// File: hw/pkt_space_ctrl.sv
// ---------------------------------------------------------------------
// pkt_space_ctrl
// keeps the used data words and the stored descriptors, and gives the
// admission level for the writer and the availability level for the
// consumer
// ---------------------------------------------------------------------

module pkt_space_ctrl (
	input  logic                          clk_a,
	input  logic                          reset,
	input  logic                          commit,		// packet stored by writer
	input  logic [pkt_buf_pkg::LEN_W-1:0] commit_len,
	input  logic                          release_pkt,	// packet freed by reader
	input  logic [pkt_buf_pkg::LEN_W-1:0] release_len,
	output logic                          admit,
	output logic                          pkt_avail
);

	logic [pkt_buf_pkg::DATA_AW:0] used_words;	// 0 .. 256
	logic [pkt_buf_pkg::DATA_AW:0] used_nxt;
	logic [pkt_buf_pkg::DESC_AW:0] desc_cnt;	// 0 .. 16
	logic [pkt_buf_pkg::DESC_AW:0] desc_nxt;

	// next counts, commit and release may share a cycle
	always_comb begin
		used_nxt = used_words;
		desc_nxt = desc_cnt;
		if (commit) begin
			used_nxt = used_nxt + (pkt_buf_pkg::DATA_AW + 1)'(commit_len);
			desc_nxt = desc_nxt + 1'b1;
		end
		if (release_pkt) begin
			used_nxt = used_nxt - (pkt_buf_pkg::DATA_AW + 1)'(release_len);
			desc_nxt = desc_nxt - 1'b1;
		end
	end

	always_ff @(posedge clk_a) begin
		if (reset) begin
			used_words <= '0;	// free count starts at 256
			desc_cnt   <= '0;
		end else begin
			used_words <= used_nxt;
			desc_cnt   <= desc_nxt;
		end
	end

	// measured on the next counts, so a packet committing this cycle
	// is already charged when the following packet starts right behind it
	assign admit = (used_nxt <= (pkt_buf_pkg::DATA_AW + 1)'(pkt_buf_pkg::USED_MAX)) &&
		(desc_nxt < (pkt_buf_pkg::DESC_AW + 1)'(pkt_buf_pkg::DESC_DEPTH));

	assign pkt_avail = (desc_cnt != '0);	// two cycles after in_last

endmodule

// File: hw/dp_sram.sv
// ---------------------------------------------------------------------
// dp_sram
// generic simple dual-port ram, one write port and one read port
// write request and read address are registered on entry, read data
// is registered again on the way out, two cycles from request to data
// ---------------------------------------------------------------------

module dp_sram #(
	parameter type payload_t = logic [7:0],	// one ram entry
	parameter int  ADDR_W    = 4			// depth is 2**ADDR_W
) (
	input  logic              clk_a,
	input  logic              reset,

	// write port
	input  logic              wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  payload_t          wr_data,

	// read port
	input  logic              rd_en,
	input  logic [ADDR_W-1:0] rd_addr,
	output payload_t          rd_data
);

	payload_t mem [2**ADDR_W];		// inferred array, no reset

	logic              wr_en_q;		// registered write request
	logic [ADDR_W-1:0] wr_addr_q;
	payload_t          wr_data_q;
	logic              rd_en_q;		// registered read request
	logic [ADDR_W-1:0] rd_addr_q;

	// input stage, enables cleared by reset
	always_ff @(posedge clk_a) begin
		if (reset) begin
			wr_en_q <= 1'b0;
			rd_en_q <= 1'b0;
		end else begin
			wr_en_q <= wr_en;
			rd_en_q <= rd_en;
		end
	end

	always_ff @(posedge clk_a) begin
		wr_addr_q <= wr_addr;
		wr_data_q <= wr_data;
		rd_addr_q <= rd_addr;
	end

	// array write lands one cycle after the request
	always_ff @(posedge clk_a) begin
		if (wr_en_q)
			mem[wr_addr_q] <= wr_data_q;
	end

	// output register holds its value between reads
	always_ff @(posedge clk_a) begin
		if (rd_en_q)
			rd_data <= mem[rd_addr_q];	// old data on same-address write
	end

endmodule

// File: hw/pkt_buf_pkg.sv
// ---------------------------------------------------------------------
// packet buffer package
// widths, depths, the packet word and the descriptor ring entry
// ---------------------------------------------------------------------

package pkt_buf_pkg;

	// data path
	localparam int DATA_W  = 32;		// bits per packet word
	localparam int DATA_AW = 8;			// data ram address bits
	localparam int DESC_AW = 4;			// descriptor ring address bits

	// packet length, 1 .. MAX_PKT_WORDS
	localparam int LEN_W         = 7;
	localparam int MAX_PKT_WORDS = 64;	// also the space a new packet must find

	localparam int DATA_DEPTH = 1 << DATA_AW;	// 256 words
	localparam int DESC_DEPTH = 1 << DESC_AW;	// 16 packets

	// highest used-word count at which a packet is still admitted
	localparam int USED_MAX = DATA_DEPTH - MAX_PKT_WORDS;

	// one packet word, data ram payload
	typedef logic [DATA_W-1:0] word_t;

	// descriptor ring entry, written at a packet's last word
	typedef struct packed {
		logic [DATA_AW-1:0] start;		// address of the first word
		logic [LEN_W-1:0]   len;		// number of words
	} pkt_desc_t;

endpackage
